// File: include/dcache_consts.svh
`ifndef DCACHE_CONSTS_SVH
`define DCACHE_CONSTS_SVH

// Address and data
`define DCACHE_ADDR_W 32
`define DCACHE_WORD_W 32

// Cache geometry
`define DCACHE_WAYS 4
`define DCACHE_SETS 16
`define DCACHE_LINE_WORDS 16

// Upper address bits above set and line offset
`define DCACHE_TAG_W 22

`endif

// File: logic/dcache_pkg.sv
`include "dcache_consts.svh"

package dcache_pkg;

  // Address fields and widths
  typedef logic [`DCACHE_ADDR_W-1:0] addr_t;
  typedef logic [`DCACHE_WORD_W-1:0] word_t;
  typedef logic [`DCACHE_WORD_W/8-1:0] wstrb_t;  // One per byte
  typedef logic [`DCACHE_TAG_W-1:0] tag_t;
  typedef logic [$clog2(`DCACHE_SETS)-1:0] set_idx_t;
  typedef logic [$clog2(`DCACHE_LINE_WORDS)-1:0] word_idx_t;
  typedef logic [$clog2(`DCACHE_WAYS)-1:0] way_idx_t;
  typedef logic [1:0] age_t;  // Sized for 4 ways

  // CPU request, req is a single-cycle pulse
  typedef struct packed {
    logic   req;
    logic   we;
    addr_t  addr;
    word_t  wdata;
    wstrb_t wstrb;
  } cpu_req_t;

  typedef enum logic [2:0] {
    st_idle, st_lookup, st_write_back, st_refill, st_finish
  } cache_state_t;

endpackage

// File: logic/mem_bus_pkg.sv
`include "dcache_consts.svh"

package mem_bus_pkg;

  // Cache to memory, rd_en and wr_en held for a whole burst
  typedef struct packed {
    logic                     rd_en;
    logic                     wr_en;
    logic [`DCACHE_ADDR_W-1:0] addr;   // Line aligned
    logic [`DCACHE_WORD_W-1:0] wdata;
  } mem_req_t;

  // Memory to cache, one strobe per word
  typedef struct packed {
    logic                     rd_valid;
    logic [`DCACHE_WORD_W-1:0] rdata;
    logic                     wr_ack;
  } mem_rsp_t;

endpackage

// File: logic/dcache_ctrl.sv
`timescale 1ns/1ps
`include "dcache_consts.svh"

module dcache_ctrl (
  input  logic                 clk,
  input  logic                 rst,
  input  dcache_pkg::cpu_req_t cpu_req,
  output dcache_pkg::word_t    rdata,
  output logic                 ok,
  output logic                 miss,
  output dcache_pkg::addr_t    lookup_addr,
  input  logic                 hit,
  input  dcache_pkg::way_idx_t hit_way,
  input  dcache_pkg::way_idx_t victim_way,
  input  logic                 victim_dirty_valid,
  input  dcache_pkg::tag_t     victim_tag,
  output logic                 touch,
  output logic                 set_dirty,
  output logic                 install,
  output dcache_pkg::way_idx_t upd_way,
  output logic                 cpu_we,
  output dcache_pkg::wstrb_t   cpu_wstrb,
  output dcache_pkg::word_t    cpu_wdata,
  output dcache_pkg::way_idx_t cpu_way,
  input  dcache_pkg::word_t    cpu_rword,
  output logic                 start_refill,
  output logic                 start_wb,
  output dcache_pkg::addr_t    line_addr,
  output dcache_pkg::way_idx_t move_way,
  input  logic                 move_done
);
  import dcache_pkg::*;

  cache_state_t state;
  cache_state_t state_nx;
  cpu_req_t     req_q;
  way_idx_t     victim_q;
  tag_t         req_tag;
  tag_t         line_tag;
  set_idx_t     req_set;

  assign req_tag = req_q.addr[`DCACHE_ADDR_W-1 -: `DCACHE_TAG_W];
  assign req_set = req_q.addr[`DCACHE_ADDR_W-`DCACHE_TAG_W-1 -: $bits(set_idx_t)];

  ////////////////////
  // State machine
  ////////////////////
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      state <= st_idle;
    else
      state <= state_nx;
  end

  always_comb
  begin
    state_nx = state;
    case (state)
      st_idle:
        if (cpu_req.req)
          state_nx = st_lookup;
      st_lookup:
        if (hit)
          state_nx = st_idle;
        else if (victim_dirty_valid)
          state_nx = st_write_back;  // Old line goes out first
        else
          state_nx = st_refill;
      st_write_back:
        if (move_done)
          state_nx = st_refill;
      st_refill:
        if (move_done)
          state_nx = st_finish;
      st_finish:
        state_nx = st_idle;
      default:
        state_nx = st_idle;
    endcase
  end

  // Request and victim are held until the request ends
  always_ff @(posedge clk)
  begin
    if (state == st_idle && cpu_req.req)
      req_q <= cpu_req;
    if (state == st_lookup)
      victim_q <= victim_way;
  end

  ////////////////////
  // Responses and strobes
  ////////////////////
  assign ok   = (state == st_lookup && hit) || state == st_finish;
  assign miss = state == st_write_back || state == st_refill;
  assign rdata = req_q.we ? req_q.wdata : cpu_rword;

  assign lookup_addr = req_q.addr;
  assign upd_way     = (state == st_lookup) ? hit_way : victim_q;
  assign touch       = ok;  // Every hit or finish counts as an access
  assign set_dirty   = ok && req_q.we;
  assign install     = state == st_refill && move_done;

  assign cpu_we    = ok && req_q.we;
  assign cpu_wstrb = req_q.wstrb;
  assign cpu_wdata = req_q.wdata;
  assign cpu_way   = upd_way;

  assign start_wb     = state == st_lookup && !hit && victim_dirty_valid;
  assign start_refill = (state == st_lookup && !hit && !victim_dirty_valid) ||
                        (state == st_write_back && move_done);
  assign line_tag     = start_wb ? victim_tag : req_tag;
  assign line_addr    = {line_tag, req_set,
                         {($bits(word_idx_t) + $clog2(`DCACHE_WORD_W/8)){1'b0}}};
  assign move_way     = victim_q;

  // Mover finishes only while a burst is awaited
  done_in_burst: assert property (@(posedge clk) disable iff (rst)
    move_done |-> (state == st_write_back || state == st_refill));

endmodule

// File: logic/dcache_tag_store.sv
`timescale 1ns/1ps
`include "dcache_consts.svh"

module dcache_tag_store (
  input  logic                 clk,
  input  logic                 rst,
  input  dcache_pkg::addr_t    lookup_addr,
  output logic                 hit,
  output dcache_pkg::way_idx_t hit_way,
  output dcache_pkg::way_idx_t victim_way,
  output logic                 victim_dirty_valid,
  output dcache_pkg::tag_t     victim_tag,
  input  logic                 touch,
  input  logic                 set_dirty,
  input  logic                 install,
  input  dcache_pkg::way_idx_t upd_way
);
  import dcache_pkg::*;

  tag_t                    tags  [`DCACHE_WAYS][`DCACHE_SETS];
  logic [`DCACHE_SETS-1:0] valid [`DCACHE_WAYS];
  logic [`DCACHE_SETS-1:0] dirty [`DCACHE_WAYS];
  age_t                    ages  [`DCACHE_WAYS][`DCACHE_SETS];

  tag_t                    tag;
  set_idx_t                set;
  logic [`DCACHE_WAYS-1:0] match;
  age_t                    upd_age;

  assign tag = lookup_addr[`DCACHE_ADDR_W-1 -: `DCACHE_TAG_W];
  assign set = lookup_addr[`DCACHE_ADDR_W-`DCACHE_TAG_W-1 -: $bits(set_idx_t)];

  ////////////////////
  // Lookup
  ////////////////////
  always_comb
  begin
    for (int w = 0; w < `DCACHE_WAYS; w++)
      match[w] = valid[w][set] && (tags[w][set] == tag);
  end

  assign hit = |match;

  always_comb
  begin
    hit_way = '0;
    for (int w = `DCACHE_WAYS-1; w >= 0; w--)
      if (match[w])
        hit_way = way_idx_t'(w);
  end

  // Oldest way first, lowest invalid way overrides
  always_comb
  begin
    victim_way = '0;
    for (int w = 1; w < `DCACHE_WAYS; w++)
      if (ages[w][set] > ages[victim_way][set])
        victim_way = way_idx_t'(w);
    for (int w = `DCACHE_WAYS-1; w >= 0; w--)
      if (!valid[w][set])
        victim_way = way_idx_t'(w);
  end

  assign victim_dirty_valid = valid[victim_way][set] && dirty[victim_way][set];
  assign victim_tag         = tags[victim_way][set];

  ////////////////////
  // Updates
  ////////////////////
  assign upd_age = ages[upd_way][set];

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      for (int w = 0; w < `DCACHE_WAYS; w++)
      begin
        valid[w] <= '0;
        dirty[w] <= '0;
        for (int s = 0; s < `DCACHE_SETS; s++)
          ages[w][s] <= '0;
      end
    end
    else
    begin
      if (install)
      begin
        valid[upd_way][set] <= 1'b1;
        dirty[upd_way][set] <= 1'b0;  // Fresh line is clean
      end
      if (set_dirty)
        dirty[upd_way][set] <= 1'b1;
      if (touch)
        for (int w = 0; w < `DCACHE_WAYS; w++)
          if (ages[w][set] <= upd_age)
            ages[w][set] <= (w == upd_way) ? age_t'(0) : ages[w][set] + 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (install)
      tags[upd_way][set] <= tag;
  end

  one_match: assert property (@(posedge clk) disable iff (rst) $onehot0(match));

endmodule

// File: logic/dcache_data_store.sv
`timescale 1ns/1ps
`include "dcache_consts.svh"

module dcache_data_store (
  input  logic                  clk,
  input  dcache_pkg::set_idx_t  set,
  input  dcache_pkg::way_idx_t  cpu_way,
  input  dcache_pkg::word_idx_t cpu_word,
  input  logic                  cpu_we,
  input  dcache_pkg::wstrb_t    cpu_wstrb,
  input  dcache_pkg::word_t     cpu_wdata,
  output dcache_pkg::word_t     cpu_rword,
  input  dcache_pkg::way_idx_t  move_way,
  input  dcache_pkg::word_idx_t move_word,
  input  logic                  fill_we,
  input  dcache_pkg::word_t     fill_data,
  output dcache_pkg::word_t     wb_word
);
  import dcache_pkg::*;

  word_t mem [`DCACHE_WAYS][`DCACHE_SETS][`DCACHE_LINE_WORDS];

  // Refill writes whole words, CPU writes by byte
  always_ff @(posedge clk)
  begin
    if (fill_we)
      mem[move_way][set][move_word] <= fill_data;
    if (cpu_we)
      for (int b = 0; b < $bits(wstrb_t); b++)
        if (cpu_wstrb[b])
          mem[cpu_way][set][cpu_word][8*b +: 8] <= cpu_wdata[8*b +: 8];
  end

  assign cpu_rword = mem[cpu_way][set][cpu_word];
  assign wb_word   = mem[move_way][set][move_word];  // Feeds write-back data

endmodule

// File: logic/dcache_line_mover.sv
`timescale 1ns/1ps

module dcache_line_mover (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  start_refill,
  input  logic                  start_wb,
  input  dcache_pkg::addr_t     line_addr,
  output logic                  done,
  output dcache_pkg::word_idx_t move_word,
  output logic                  fill_we,
  output dcache_pkg::word_t     fill_data,
  input  dcache_pkg::word_t     wb_word,
  output mem_bus_pkg::mem_req_t mem_req,
  input  mem_bus_pkg::mem_rsp_t mem_rsp
);
  import dcache_pkg::*;

  logic      busy;
  logic      wb_mode;  // Low for refill
  word_idx_t cnt;
  addr_t     addr_q;
  logic      strobe;

  assign strobe = busy && (wb_mode ? mem_rsp.wr_ack : mem_rsp.rd_valid);

  ////////////////////
  // Burst control
  ////////////////////
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      busy    <= 1'b0;
      wb_mode <= 1'b0;
      cnt     <= '0;
      done    <= 1'b0;
    end
    else
    begin
      done <= strobe && (cnt == '1);
      if (!busy && (start_refill || start_wb))
      begin
        busy    <= 1'b1;
        wb_mode <= start_wb;
        cnt     <= '0;
      end
      else if (strobe)
      begin
        cnt <= cnt + 1'b1;  // Wraps to 0 after the last word
        if (cnt == '1)
          busy <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (!busy && (start_refill || start_wb))
      addr_q <= line_addr;
  end

  assign move_word = cnt;
  assign fill_we   = strobe && !wb_mode;
  assign fill_data = mem_rsp.rdata;

  always_comb
  begin
    mem_req.rd_en = busy && !wb_mode;
    mem_req.wr_en = busy && wb_mode;
    mem_req.addr  = addr_q;
    mem_req.wdata = wb_word;
  end

  // A start during a burst would be dropped
  no_start_busy: assert property (@(posedge clk) disable iff (rst)
    (start_refill || start_wb) |-> !busy);

endmodule

// File: logic/dcache_top.sv
`timescale 1ns/1ps
`include "dcache_consts.svh"

module dcache_top (
  input  logic                  clk,
  input  logic                  rst,
  input  dcache_pkg::cpu_req_t  cpu_req,
  output dcache_pkg::word_t     rdata,
  output logic                  ok,
  output logic                  miss,
  output mem_bus_pkg::mem_req_t mem_req,
  input  mem_bus_pkg::mem_rsp_t mem_rsp
);
  import dcache_pkg::*;

  addr_t     lookup_addr;
  logic      hit;
  way_idx_t  hit_way;
  way_idx_t  victim_way;
  logic      victim_dirty_valid;
  tag_t      victim_tag;
  logic      touch;
  logic      set_dirty;
  logic      install;
  way_idx_t  upd_way;
  logic      cpu_we;
  wstrb_t    cpu_wstrb;
  word_t     cpu_wdata;
  way_idx_t  cpu_way;
  word_t     cpu_rword;
  logic      start_refill;
  logic      start_wb;
  addr_t     line_addr;
  way_idx_t  move_way;
  logic      move_done;
  set_idx_t  set;
  word_idx_t cpu_word;
  word_idx_t move_word;
  logic      fill_we;
  word_t     fill_data;
  word_t     wb_word;

  // Set and word fields of the held request
  assign set      = lookup_addr[`DCACHE_ADDR_W-`DCACHE_TAG_W-1 -: $bits(set_idx_t)];
  assign cpu_word = lookup_addr[$clog2(`DCACHE_WORD_W/8) +: $bits(word_idx_t)];

  dcache_ctrl u_ctrl (
    .clk, .rst, .cpu_req, .rdata, .ok, .miss,
    .lookup_addr, .hit, .hit_way, .victim_way, .victim_dirty_valid, .victim_tag,
    .touch, .set_dirty, .install, .upd_way,
    .cpu_we, .cpu_wstrb, .cpu_wdata, .cpu_way, .cpu_rword,
    .start_refill, .start_wb, .line_addr, .move_way, .move_done
  );

  dcache_tag_store u_tag_store (
    .clk, .rst, .lookup_addr, .hit, .hit_way, .victim_way,
    .victim_dirty_valid, .victim_tag, .touch, .set_dirty, .install, .upd_way
  );

  dcache_data_store u_data_store (
    .clk, .set, .cpu_way, .cpu_word, .cpu_we, .cpu_wstrb, .cpu_wdata, .cpu_rword,
    .move_way, .move_word, .fill_we, .fill_data, .wb_word
  );

  dcache_line_mover u_line_mover (
    .clk, .rst, .start_refill, .start_wb, .line_addr, .done(move_done),
    .move_word, .fill_we, .fill_data, .wb_word, .mem_req, .mem_rsp
  );

endmodule

// File: dv/dcache_mem_model.sv
`timescale 1ns/1ps
`include "dcache_consts.svh"

module dcache_mem_model (
  input  logic                  clk,
  input  logic                  rst,
  input  mem_bus_pkg::mem_req_t mem_req,
  output mem_bus_pkg::mem_rsp_t mem_rsp
);
  import mem_bus_pkg::*;

  localparam logic [31:0] fill_key = 32'h5a3c_96e1;
  localparam int depth = 4096;  // Byte addresses below 16 KiB

  logic [`DCACHE_WORD_W-1:0] store [depth];
  int line_words [depth/16];  // Words taken by the last write burst per line
  int issued;
  int taken;
  int gap;

  initial
  begin
    for (int i = 0; i < depth; i++)
      store[i] = (i * 4) ^ fill_key;
    for (int i = 0; i < depth/16; i++)
      line_words[i] = 0;
  end

  ////////////////////
  // Burst responder
  ////////////////////
  always @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      mem_rsp <= '0;
      issued = 0;
      taken  = 0;
      gap    = 0;
    end
    else
    begin
      mem_rsp.rd_valid <= 1'b0;
      mem_rsp.wr_ack   <= 1'b0;
      // Ack seen by the cache on this edge, so wdata is the acked word
      if (mem_rsp.wr_ack && mem_req.wr_en)
      begin
        if (taken == 0)
          line_words[mem_req.addr[13:6]] = 0;
        store[mem_req.addr[13:2] + 12'(taken)] = mem_req.wdata;
        line_words[mem_req.addr[13:6]]++;
        taken++;
      end
      if (!mem_req.rd_en && !mem_req.wr_en)
      begin
        issued = 0;
        taken  = 0;
        gap    = $urandom % 4;
      end
      else if (issued < `DCACHE_LINE_WORDS)
      begin
        if (gap > 0)
          gap--;  // Stall
        else
        begin
          if (mem_req.rd_en)
          begin
            mem_rsp.rd_valid <= 1'b1;
            mem_rsp.rdata    <= store[mem_req.addr[13:2] + 12'(issued)];
          end
          else
            mem_rsp.wr_ack <= 1'b1;
          issued++;
          gap = $urandom % 4;
        end
      end
    end
  end

endmodule

// File: dv/dcache_tb.sv
`timescale 1ns/1ps
`include "dcache_consts.svh"

module dcache_tb;
  import dcache_pkg::*;
  import mem_bus_pkg::*;

  localparam logic [31:0] fill_key = 32'h5a3c_96e1;
  localparam int wait_limit = 2000;

  logic     clk;
  logic     rst;
  cpu_req_t cpu_req;
  word_t    rdata;
  logic     ok;
  logic     miss;
  mem_req_t mem_req;
  mem_rsp_t mem_rsp;

  // Reference cache
  tag_t  ref_tag   [`DCACHE_WAYS][`DCACHE_SETS];
  logic  ref_valid [`DCACHE_WAYS][`DCACHE_SETS];
  logic  ref_dirty [`DCACHE_WAYS][`DCACHE_SETS];
  age_t  ref_age   [`DCACHE_WAYS][`DCACHE_SETS];
  word_t ref_data  [`DCACHE_WAYS][`DCACHE_SETS][`DCACHE_LINE_WORDS];
  word_t ref_mem   [4096];  // Same 16 KiB window as the memory model

  int   errors;
  logic hung;
  int   seed_draw;

  dcache_top dut (.clk, .rst, .cpu_req, .rdata, .ok, .miss, .mem_req, .mem_rsp);

  dcache_mem_model mem (.clk, .rst, .mem_req, .mem_rsp);

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
    errors++;
    $display("error @%0t ns: %s expected %h, got %h", $time, name, exp, act);
  endtask

  task automatic report_failure(input string what);
    errors++;
    $display("@%0t ns: %s", $time, what);
  endtask

  ////////////////////
  // Reference model
  ////////////////////
  function automatic int victim_of(input set_idx_t s);
    int best;
    for (int i = 0; i < `DCACHE_WAYS; i++)
      if (!ref_valid[i][s])
        return i;
    best = 0;
    for (int i = 1; i < `DCACHE_WAYS; i++)
      if (ref_age[i][s] > ref_age[best][s])
        best = i;  // Strict compare keeps the lowest way on a tie
    return best;
  endfunction

  task automatic ref_access(input logic we, input addr_t addr, input word_t wdata,
                            input wstrb_t wstrb, output logic exp_hit, output logic exp_wb,
                            output addr_t wb_line, output word_t exp_rdata);
    set_idx_t  s;
    tag_t      t;
    word_idx_t k;
    int        w;
    age_t      a;
    s = addr[9:6];
    t = addr[31:10];
    k = addr[5:2];
    w = -1;
    for (int i = 0; i < `DCACHE_WAYS; i++)
      if (ref_valid[i][s] && ref_tag[i][s] == t)
        w = i;
    exp_hit = w >= 0;
    exp_wb  = 1'b0;
    wb_line = '0;
    if (!exp_hit)
    begin
      w = victim_of(s);
      if (ref_valid[w][s] && ref_dirty[w][s])
      begin
        exp_wb  = 1'b1;
        wb_line = {ref_tag[w][s], s, 6'b0};
        for (int i = 0; i < `DCACHE_LINE_WORDS; i++)
          ref_mem[{wb_line[13:6], 4'(i)}] = ref_data[w][s][i];
      end
      for (int i = 0; i < `DCACHE_LINE_WORDS; i++)
        ref_data[w][s][i] = ref_mem[{addr[13:6], 4'(i)}];
      ref_tag[w][s]   = t;
      ref_valid[w][s] = 1'b1;
      ref_dirty[w][s] = 1'b0;
    end
    if (we)
    begin
      for (int b = 0; b < 4; b++)
        if (wstrb[b])
          ref_data[w][s][k][8*b +: 8] = wdata[8*b +: 8];
      ref_dirty[w][s] = 1'b1;
    end
    exp_rdata = we ? wdata : ref_data[w][s][k];
    a = ref_age[w][s];
    for (int i = 0; i < `DCACHE_WAYS; i++)
      if (ref_age[i][s] <= a)
        ref_age[i][s] = (i == w) ? age_t'(0) : ref_age[i][s] + 1'b1;
  endtask

  // One CPU request, checked against the reference
  task automatic run_access(input logic we, input addr_t addr, input word_t wdata,
                            input wstrb_t wstrb);
    logic  exp_hit;
    logic  exp_wb;
    addr_t wb_line;
    word_t exp_rdata;
    logic  got_ok;
    logic  saw_miss;
    int    n;
    int    rd_at;
    int    wr_at;
    addr_t rd_addr;
    addr_t wr_addr;
    if (hung)
      return;
    ref_access(we, addr, wdata, wstrb, exp_hit, exp_wb, wb_line, exp_rdata);
    @(posedge clk);
    cpu_req <= {1'b1, we, addr, wdata, wstrb};
    @(posedge clk);
    cpu_req.req <= 1'b0;
    got_ok   = 1'b0;
    saw_miss = 1'b0;
    rd_at    = -1;
    wr_at    = -1;
    n        = 0;
    while (!got_ok && n < wait_limit)
    begin
      @(negedge clk);
      n++;
      if (miss)
        saw_miss = 1'b1;
      if (mem_req.rd_en && rd_at < 0)
      begin
        rd_at   = n;
        rd_addr = mem_req.addr;
      end
      if (mem_req.wr_en && wr_at < 0)
      begin
        wr_at   = n;
        wr_addr = mem_req.addr;
      end
      if (ok)
      begin
        got_ok = 1'b1;
        if (rdata !== exp_rdata)
          report_mismatch("rdata", exp_rdata, rdata);
      end
    end
    if (!got_ok)
    begin
      hung = 1'b1;
      report_failure($sformatf("no ok within %0d cycles for address %h", wait_limit, addr));
    end
    else if (exp_hit)
    begin
      if (n != 1)
        report_failure($sformatf("hit at %h answered after %0d cycles", addr, n));
      if (saw_miss)
        report_mismatch("miss", 0, 1);
      if (rd_at >= 0)
        report_failure($sformatf("rd_en rose on a hit at %h", addr));
    end
    else
    begin
      if (!saw_miss)
        report_mismatch("miss", 1, 0);
      if (rd_at < 0)
        report_failure($sformatf("rd_en never rose on a miss at %h", addr));
      else if (rd_addr !== {addr[31:6], 6'b0})
        report_mismatch("mem_req.addr", {addr[31:6], 6'b0}, rd_addr);
      if (exp_wb)
      begin
        if (wr_at < 0 || wr_at > rd_at)
          report_failure($sformatf("no write-back before the refill of %h", addr));
        else if (wr_addr !== wb_line)
          report_mismatch("mem_req.addr", wb_line, wr_addr);
      end
      else if (wr_at >= 0)
        report_failure($sformatf("wr_en rose without a dirty victim at %h", addr));
    end
  endtask

  ////////////////////
  // Directed tests
  ////////////////////
  task automatic check_reset_state();
    if (ok !== 1'b0)
      report_mismatch("ok", 0, ok);
    if (miss !== 1'b0)
      report_mismatch("miss", 0, miss);
    if (mem_req.rd_en !== 1'b0)
      report_mismatch("mem_req.rd_en", 0, mem_req.rd_en);
    if (mem_req.wr_en !== 1'b0)
      report_mismatch("mem_req.wr_en", 0, mem_req.wr_en);
  endtask

  task automatic read_miss_then_hit();
    run_access(1'b0, 32'h0000_0044, '0, '0);
    run_access(1'b0, 32'h0000_0078, '0, '0);  // Same line
  endtask

  task automatic write_hit_merge();
    run_access(1'b1, 32'h0000_0044, 32'haabb_ccdd, 4'b0101);
    run_access(1'b0, 32'h0000_0044, '0, '0);
  endtask

  // Five lines in set 3
  task automatic replace_in_set();
    int    v;
    addr_t gone;
    for (int k = 0; k < 4; k++)
      run_access(1'b0, 32'h0000_00c0 + k * 32'h400, '0, '0);
    run_access(1'b1, 32'h0000_08c4, $urandom, 4'b0011);
    run_access(1'b0, 32'h0000_00c8, '0, '0);
    v    = victim_of(4'd3);
    gone = {ref_tag[v][3], 4'd3, 6'b0};
    run_access(1'b0, 32'h0000_10c0, '0, '0);
    for (int k = 0; k < 5; k++)
      if (32'h0000_00c0 + k * 32'h400 != gone)
        run_access(1'b0, 32'h0000_00cc + k * 32'h400, '0, '0);
    run_access(1'b0, gone + 32'h10, '0, '0);
  endtask

  task automatic write_miss_evict();
    word_t wdata;
    wdata = $urandom;
    run_access(1'b1, 32'h0000_0148, wdata, 4'b1111);
    for (int k = 1; k < 5; k++)
      run_access(1'b0, 32'h0000_0140 + k * 32'h400, '0, '0);
    if (!hung)
    begin
      for (int i = 0; i < `DCACHE_LINE_WORDS; i++)
        if (mem.store[{8'h05, 4'(i)}] !== ref_mem[{8'h05, 4'(i)}])
          report_mismatch("mem.store", ref_mem[{8'h05, 4'(i)}], mem.store[{8'h05, 4'(i)}]);
      if (mem.store[12'h052] !== wdata)
        report_mismatch("mem.store", wdata, mem.store[12'h052]);
      if (mem.line_words[8'h05] != `DCACHE_LINE_WORDS)
        report_failure($sformatf("line 0x140 got %0d written words", mem.line_words[8'h05]));
    end
  endtask

  initial
  begin
    seed_draw = $urandom(27);
    errors    = 0;
    hung      = 1'b0;
    rst       = 1'b1;
    cpu_req   = '0;
    for (int i = 0; i < 4096; i++)
      ref_mem[i] = (i * 4) ^ fill_key;
    for (int w = 0; w < `DCACHE_WAYS; w++)
      for (int s = 0; s < `DCACHE_SETS; s++)
      begin
        ref_tag[w][s]   = '0;
        ref_valid[w][s] = 1'b0;
        ref_dirty[w][s] = 1'b0;
        ref_age[w][s]   = '0;
      end
    repeat (8) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    check_reset_state();
    read_miss_then_hit();
    write_hit_merge();
    replace_in_set();
    write_miss_evict();
    $display("errors: %0d", errors);
    if (errors == 0)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  end

endmodule

// File: dcache.f
+incdir+include
logic/dcache_pkg.sv
logic/mem_bus_pkg.sv
logic/dcache_ctrl.sv
logic/dcache_tag_store.sv
logic/dcache_data_store.sv
logic/dcache_line_mover.sv
logic/dcache_top.sv
dv/dcache_mem_model.sv
dv/dcache_tb.sv

// File: Bender.yml
package:
  name: dcache

export_include_dirs:
  - include

sources:
  - logic/dcache_pkg.sv
  - logic/mem_bus_pkg.sv
  - logic/dcache_ctrl.sv
  - logic/dcache_tag_store.sv
  - logic/dcache_data_store.sv
  - logic/dcache_line_mover.sv
  - logic/dcache_top.sv
  - target: test
    files:
      - dv/dcache_mem_model.sv
      - dv/dcache_tb.sv
